//--- test/dma_iface_vectors.txt
// columns: group_op_ifsel_memsel_addr_mask_hidata_lodata, one hex word per row
// op 1 write lo, 2 write hi, 3 write both, 4 read and compare, 5 compare output port
// interface 0 is this slice, size codes are at 0 during group 2
2_3_0_0_000_f_11223344_55667788
2_4_0_0_000_0_11223344_55667788
2_1_0_0_000_5_00000000_aabbccdd
2_2_0_0_000_a_99eeff00_00000000
2_4_0_0_000_0_9922ff44_55bb77dd
2_3_0_0_001_3_01020304_a0b0c0d0
2_3_0_0_001_c_cafef00d_12345678
2_4_0_0_001_0_cafe0304_1234c0d0
2_1_0_0_002_f_00000000_fedcba98
2_4_0_0_002_0_00000000_0000ba98
2_1_0_0_002_2_00000000_00001100
2_2_0_0_002_f_ffffffff_00000000
2_4_0_0_002_0_00000000_00001198
2_1_0_0_004_f_00000000_ffffffff
2_4_0_0_004_0_00000020_00000020
2_4_0_0_003_0_00000000_00000000
2_4_0_0_005_0_00000000_00000000
2_5_0_0_000_0_9922ff44_55bb77dd
2_5_0_0_001_0_cafe0304_1234c0d0
2_5_0_0_002_0_00000000_00001198
5_4_1_0_000_0_deadbeef_deadbeef
5_4_0_2_000_0_deadbeef_deadbeef
5_4_0_f_003_0_deadbeef_deadbeef
5_4_0_1_000_0_deadbeef_deadbeef
5_3_1_0_000_f_00000000_00000000
5_1_3_0_002_f_00000000_00000000
5_3_2_0_001_f_ffffffff_ffffffff
5_1_2_0_003_f_00000000_00000001
5_3_0_7_000_f_00000000_00000000
5_4_0_0_000_0_9922ff44_55bb77dd
5_4_0_0_001_0_cafe0304_1234c0d0
5_4_0_0_002_0_00000000_00001198
5_5_0_0_000_0_9922ff44_55bb77dd
0_0_0_0_000_0_00000000_00000000

//--- dma_iface.f
hw/dma_iface_pkg.sv
hw/dma_pcie_pkg.sv
hw/iface_rst_seq.sv
hw/iface_access_mux.sv
hw/iface_cfg_regs.sv
hw/pcie_size_decode.sv
hw/tx_dsc_mem.sv
hw/dma_iface.sv
test/tb_clk_gen.sv
test/tb_dma_iface.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_dma_iface
FILELIST  := dma_iface.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := PASS: all tests

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_dma_iface.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dma_iface;

   import dma_iface_pkg::*;
   import dma_pcie_pkg::*;

   localparam int IFACE_ID  = 0;
   localparam int DSC_DEPTH = 16;
   localparam int IDX_BITS  = $clog2(DSC_DEPTH);
   localparam int VEC_DEPTH = 64;
   localparam if_sel_t MY_IF = if_sel_t'(IFACE_ID);

   typedef logic [IDX_BITS-1:0] dsc_idx_t;

   logic            pcie_clk;
   logic            rst_n;
   host_wr_t        host_wr;
   host_rd_t        host_rd;
   host_rd_data_t   host_rd_data;
   pcie_size_code_t max_payload_size;
   pcie_size_code_t max_read_req_size;
   logic            iface_rdy;
   dsc_word_t       tx_dsc_mask;
   dsc_word_t       rx_dsc_mask;
   logic [15:0]     rx_byte_wait;
   dsc_idx_t        dsc_rd_addr;
   logic            dsc_rd_en;
   dsc_word_t       dsc_rd_data;
   logic            dsc_rd_valid;
   dsc_idx_t        dsc_clr_addr;
   logic            dsc_clr_en;

   // group, op, if_sel, mem_sel, addr, mask, hi word, lo word
   logic [95:0] vecs [VEC_DEPTH];
   dsc_word_t   exp_dsc [DSC_DEPTH];
   logic [31:0] lfsr;
   int          checks;
   int          errors;
   int          test_err_base;
   int          tests_passed;
   int          tests_failed;

   tb_clk_gen #(.PERIOD_NS(4)) u_clk_gen (.clk(pcie_clk));

   dma_iface #(.IFACE_ID(IFACE_ID), .DSC_DEPTH(DSC_DEPTH)) u_dma_iface (
      .pcie_clk          (pcie_clk),
      .rst_n             (rst_n),
      .host_wr           (host_wr),
      .host_rd           (host_rd),
      .host_rd_data      (host_rd_data),
      .max_payload_size  (max_payload_size),
      .max_read_req_size (max_read_req_size),
      .iface_rdy         (iface_rdy),
      .tx_dsc_mask       (tx_dsc_mask),
      .rx_dsc_mask       (rx_dsc_mask),
      .rx_byte_wait      (rx_byte_wait),
      .dsc_rd_addr       (dsc_rd_addr),
      .dsc_rd_en         (dsc_rd_en),
      .dsc_rd_data       (dsc_rd_data),
      .dsc_rd_valid      (dsc_rd_valid),
      .dsc_clr_addr      (dsc_clr_addr),
      .dsc_clr_en        (dsc_clr_en)
   );

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_word(output logic [31:0] w);
      for (int b = 0; b < 32; b++) begin
         lfsr = lfsr_next(lfsr);
         w[b] = lfsr[0];
      end
   endtask

   // 32 << code, 1024 wraps to 0, reserved codes give 0
   function automatic pcie_bytes_t expect_bytes(int code);
      if (code <= 5) begin
         return pcie_bytes_t'(32 << code);
      end
      return '0;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, want);
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == test_err_base) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - test_err_base);
      end
      test_err_base = errors;
   endtask

   task automatic wait_rdy(input logic level, input int limit);
      int n;
      n = 0;
      while (iface_rdy !== level && n < limit) begin
         @(negedge pcie_clk);
         n++;
      end
      if (iface_rdy !== level) begin
         errors++;
         $display("timeout: iface_rdy did not reach %0b within %0d cycles", level, limit);
      end
   endtask

   task automatic host_write(input if_sel_t ifs, input mem_sel_t ms, input mem_addr_t addr,
                             input byte_mask_t mask, input logic hi_en, input logic lo_en,
                             input host_word_t hi_data, input host_word_t lo_data);
      host_wr_t w;
      w         = '0;
      w.if_sel  = ifs;
      w.mem_sel = ms;
      w.hi.addr = addr;
      w.hi.data = hi_data;
      w.hi.mask = mask;
      w.hi.en   = hi_en;
      w.lo.addr = addr;
      w.lo.data = lo_data;
      w.lo.mask = mask;
      w.lo.en   = lo_en;
      @(posedge pcie_clk);
      host_wr <= w;
      @(posedge pcie_clk);
      host_wr <= '0;
   endtask

   // data is back on the first edge after the enable
   task automatic host_read(input if_sel_t ifs, input mem_sel_t ms, input mem_addr_t addr,
                            output host_rd_data_t d);
      host_rd_t r;
      r         = '0;
      r.if_sel  = ifs;
      r.mem_sel = ms;
      r.addr_hi = addr;
      r.en_hi   = 1'b1;
      r.addr_lo = addr;
      r.en_lo   = 1'b1;
      @(posedge pcie_clk);
      host_rd <= r;
      @(posedge pcie_clk);
      host_rd <= '0;
      @(negedge pcie_clk);
      d = host_rd_data;
   endtask

   task automatic engine_read(input dsc_idx_t idx, output dsc_word_t d, output logic v);
      @(posedge pcie_clk);
      dsc_rd_addr <= idx;
      dsc_rd_en   <= 1'b1;
      @(posedge pcie_clk);
      dsc_rd_en   <= 1'b0;
      @(negedge pcie_clk);
      d = dsc_rd_data;
      v = dsc_rd_valid;
   endtask

   task automatic engine_clear(input dsc_idx_t idx);
      @(posedge pcie_clk);
      dsc_clr_addr <= idx;
      dsc_clr_en   <= 1'b1;
      @(posedge pcie_clk);
      dsc_clr_en   <= 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // tests
   // ----------------------------------------------------------------------
   task automatic run_vectors(input logic [3:0] group);
      logic [95:0]   v;
      host_rd_data_t d;
      dsc_word_t     got;
      for (int i = 0; i < VEC_DEPTH; i++) begin
         v = vecs[i];
         if (v[91:88] == 4'd0) begin
            break;
         end
         if (v[95:92] == group) begin
            case (v[91:88])
               4'd1, 4'd2, 4'd3: begin
                  host_write(if_sel_t'(v[87:84]), mem_sel_t'(v[83:80]),
                             mem_addr_t'(v[79:68]), v[67:64], v[89], v[88],
                             v[63:32], v[31:0]);
               end
               4'd4: begin
                  host_read(if_sel_t'(v[87:84]), mem_sel_t'(v[83:80]),
                            mem_addr_t'(v[79:68]), d);
                  check_value($sformatf("vector %0d read", i), d, v[63:0]);
               end
               4'd5: begin
                  @(negedge pcie_clk);
                  case (v[79:68])
                     12'd0:   got = tx_dsc_mask;
                     12'd1:   got = rx_dsc_mask;
                     default: got = {48'd0, rx_byte_wait};
                  endcase
                  check_value($sformatf("vector %0d output port", i), got, v[63:0]);
               end
               default: begin
                  errors++;
                  $display("vector %0d has an unknown operation code", i);
               end
            endcase
         end
      end
   endtask

   task automatic test_reset();
      host_rd_data_t d;
      wait_rdy(1'b1, 40);
      for (int r = 0; r < 4; r++) begin
         host_read(MY_IF, MEM_CFG, mem_addr_t'(r), d);
         check_value($sformatf("config reg %0d after reset", r), d, 64'd0);
      end
      finish_test("test 1 reset");
   endtask

   task automatic test_sizes();
      host_rd_data_t d;
      dsc_word_t     want;
      for (int c = 0; c < 8; c++) begin
         @(posedge pcie_clk);
         max_payload_size  <= pcie_size_code_t'(c);
         max_read_req_size <= pcie_size_code_t'(7 - c);
         repeat (3) @(posedge pcie_clk);
         host_read(MY_IF, MEM_CFG, CFG_PCIE_SIZES, d);
         want = {22'd0, expect_bytes(7 - c), 22'd0, expect_bytes(c)};
         check_value($sformatf("pcie sizes, payload code %0d", c), d, want);
      end
      finish_test("test 3 pcie sizes");
   endtask

   task automatic test_descriptors();
      dsc_word_t   d;
      logic        v;
      logic [31:0] hi_w;
      logic [31:0] lo_w;
      // entry 0 is untouched since reset
      rand_word(lo_w);
      host_write(MY_IF, MEM_TX_DSC, 10'd0, 4'hf, 1'b0, 1'b1, 32'd0, lo_w);
      engine_read(dsc_idx_t'(0), d, v);
      check_value("lo-only entry 0 valid", 64'(v), 64'd0);
      check_value("lo-only entry 0 lo data", {32'd0, d[31:0]}, {32'd0, lo_w});
      for (int i = 0; i < DSC_DEPTH; i++) begin
         rand_word(hi_w);
         rand_word(lo_w);
         exp_dsc[i] = {hi_w, lo_w};
         host_write(MY_IF, MEM_TX_DSC, mem_addr_t'(i), 4'hf, 1'b1, 1'b1, hi_w, lo_w);
      end
      for (int i = 0; i < DSC_DEPTH; i++) begin
         engine_read(dsc_idx_t'(i), d, v);
         check_value($sformatf("entry %0d data", i), d, exp_dsc[i]);
         check_value($sformatf("entry %0d valid", i), 64'(v), 64'd1);
      end
      engine_clear(dsc_idx_t'(5));
      engine_read(dsc_idx_t'(5), d, v);
      check_value("cleared entry 5 valid", 64'(v), 64'd0);
      check_value("cleared entry 5 data", d, exp_dsc[5]);
      finish_test("test 4 descriptor memory");
   endtask

   task automatic test_soft_reset();
      host_rd_data_t d;
      dsc_word_t     dd;
      logic          v;
      host_write(MY_IF, MEM_CFG, CFG_CONTROL, 4'h1, 1'b0, 1'b1, 32'd0, 32'd1);
      wait_rdy(1'b0, 8);
      wait_rdy(1'b1, 40);
      for (int r = 0; r < 3; r++) begin
         host_read(MY_IF, MEM_CFG, mem_addr_t'(r), d);
         check_value($sformatf("config reg %0d after soft reset", r), d, 64'd0);
      end
      for (int i = 0; i < DSC_DEPTH; i++) begin
         engine_read(dsc_idx_t'(i), dd, v);
         check_value($sformatf("entry %0d valid after soft reset", i), 64'(v), 64'd0);
      end
      finish_test("test 6 soft reset");
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      rst_n             <= 1'b0;
      host_wr           <= '0;
      host_rd           <= '0;
      max_payload_size  <= SIZE_32;
      max_read_req_size <= SIZE_32;
      dsc_rd_addr       <= '0;
      dsc_rd_en         <= 1'b0;
      dsc_clr_addr      <= '0;
      dsc_clr_en        <= 1'b0;
      lfsr              = 32'hae71;
      checks            = 0;
      errors            = 0;
      test_err_base     = 0;
      tests_passed      = 0;
      tests_failed      = 0;

      $readmemh("test/dma_iface_vectors.txt", vecs);
      if (vecs[0][91:88] == 4'd0) begin
         errors++;
         $display("vector file test/dma_iface_vectors.txt is missing or empty");
      end

      repeat (16) @(posedge pcie_clk);
      rst_n <= 1'b1;

      test_reset();
      run_vectors(4'd2);
      finish_test("test 2 config writes");
      test_sizes();
      test_descriptors();
      run_vectors(4'd5);
      finish_test("test 5 foreign and unmapped access");
      test_soft_reset();

      $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
               tests_passed, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk
);

   // free running, starts low
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- hw/dma_iface.sv
`timescale 1ns/100ps
`default_nettype none

module dma_iface #(
   parameter int IFACE_ID  = 0,
   parameter int DSC_DEPTH = 16
) (
   input  logic                          pcie_clk,
   input  logic                          rst_n,
   input  dma_iface_pkg::host_wr_t       host_wr,
   input  dma_iface_pkg::host_rd_t       host_rd,
   output dma_iface_pkg::host_rd_data_t  host_rd_data,
   input  dma_pcie_pkg::pcie_size_code_t max_payload_size,
   input  dma_pcie_pkg::pcie_size_code_t max_read_req_size,
   output logic                          iface_rdy,
   output dma_iface_pkg::dsc_word_t      tx_dsc_mask,
   output dma_iface_pkg::dsc_word_t      rx_dsc_mask,
   output logic [15:0]                   rx_byte_wait,
   input  logic [$clog2(DSC_DEPTH)-1:0]  dsc_rd_addr,
   input  logic                          dsc_rd_en,
   output dma_iface_pkg::dsc_word_t      dsc_rd_data,
   output logic                          dsc_rd_valid,
   input  logic [$clog2(DSC_DEPTH)-1:0]  dsc_clr_addr,
   input  logic                          dsc_clr_en
);

   import dma_iface_pkg::*;
   import dma_pcie_pkg::*;

   logic          iface_rst_n;
   logic          soft_reset;
   host_wr_t      cfg_wr;
   host_wr_t      dsc_wr;
   host_rd_t      cfg_rd;
   host_rd_data_t cfg_rd_data;
   pcie_bytes_t   payload_bytes;
   pcie_bytes_t   read_bytes;

   iface_rst_seq u_rst_seq (
      .pcie_clk    (pcie_clk),
      .rst_n       (rst_n),
      .soft_reset  (soft_reset),
      .iface_rst_n (iface_rst_n),
      .iface_rdy   (iface_rdy)
   );

   iface_access_mux #(.IFACE_ID(IFACE_ID)) u_access_mux (
      .pcie_clk     (pcie_clk),
      .iface_rst_n  (iface_rst_n),
      .iface_rdy    (iface_rdy),
      .host_wr      (host_wr),
      .host_rd      (host_rd),
      .cfg_wr       (cfg_wr),
      .dsc_wr       (dsc_wr),
      .cfg_rd       (cfg_rd),
      .cfg_rd_data  (cfg_rd_data),
      .host_rd_data (host_rd_data)
   );

   iface_cfg_regs u_cfg_regs (
      .pcie_clk      (pcie_clk),
      .iface_rst_n   (iface_rst_n),
      .cfg_wr        (cfg_wr),
      .cfg_rd        (cfg_rd),
      .cfg_rd_data   (cfg_rd_data),
      .payload_bytes (payload_bytes),
      .read_bytes    (read_bytes),
      .tx_dsc_mask   (tx_dsc_mask),
      .rx_dsc_mask   (rx_dsc_mask),
      .rx_byte_wait  (rx_byte_wait),
      .soft_reset    (soft_reset)
   );

   pcie_size_decode u_size_decode (
      .pcie_clk          (pcie_clk),
      .max_payload_size  (max_payload_size),
      .max_read_req_size (max_read_req_size),
      .payload_bytes     (payload_bytes),
      .read_bytes        (read_bytes)
   );

   // engine side ports pass straight to the descriptor memory
   tx_dsc_mem #(.DSC_DEPTH(DSC_DEPTH)) u_tx_dsc_mem (
      .pcie_clk     (pcie_clk),
      .iface_rst_n  (iface_rst_n),
      .dsc_wr       (dsc_wr),
      .dsc_rd_addr  (dsc_rd_addr),
      .dsc_rd_en    (dsc_rd_en),
      .dsc_rd_data  (dsc_rd_data),
      .dsc_rd_valid (dsc_rd_valid),
      .dsc_clr_addr (dsc_clr_addr),
      .dsc_clr_en   (dsc_clr_en)
   );

endmodule

`default_nettype wire

//--- hw/tx_dsc_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tx_dsc_mem #(
   parameter int DSC_DEPTH = 16
) (
   input  logic                         pcie_clk,
   input  logic                         iface_rst_n,
   input  dma_iface_pkg::host_wr_t      dsc_wr,
   input  logic [$clog2(DSC_DEPTH)-1:0] dsc_rd_addr,
   input  logic                         dsc_rd_en,
   output dma_iface_pkg::dsc_word_t     dsc_rd_data,
   output logic                         dsc_rd_valid,
   input  logic [$clog2(DSC_DEPTH)-1:0] dsc_clr_addr,
   input  logic                         dsc_clr_en
);

   import dma_iface_pkg::*;

   localparam int IDX_BITS = $clog2(DSC_DEPTH);

   host_word_t           mem_hi [DSC_DEPTH];
   host_word_t           mem_lo [DSC_DEPTH];
   logic [DSC_DEPTH-1:0] valid;
   logic [IDX_BITS-1:0]  hi_idx;
   logic [IDX_BITS-1:0]  lo_idx;

   assign hi_idx = dsc_wr.hi.addr[IDX_BITS-1:0];
   assign lo_idx = dsc_wr.lo.addr[IDX_BITS-1:0];

   // ----------------------------------------------------------------------
   // descriptor storage
   // ----------------------------------------------------------------------
   always_ff @(posedge pcie_clk) begin
      for (int b = 0; b < 4; b++) begin
         if (dsc_wr.hi.en && dsc_wr.hi.mask[b]) begin
            mem_hi[hi_idx][8*b +: 8] <= dsc_wr.hi.data[8*b +: 8];
         end
         if (dsc_wr.lo.en && dsc_wr.lo.mask[b]) begin
            mem_lo[lo_idx][8*b +: 8] <= dsc_wr.lo.data[8*b +: 8];
         end
      end
      if (dsc_rd_en) begin
         dsc_rd_data <= {mem_hi[dsc_rd_addr], mem_lo[dsc_rd_addr]};
      end
   end

   // ----------------------------------------------------------------------
   // valid bits
   // ----------------------------------------------------------------------

   // hi lane write marks the entry ready for the engine
   always_ff @(posedge pcie_clk) begin
      if (!iface_rst_n) begin
         valid        <= '0;
         dsc_rd_valid <= 1'b0;
      end else begin
         if (dsc_clr_en) begin
            valid[dsc_clr_addr] <= 1'b0;
         end
         // host write wins over an engine clear of the same entry
         if (dsc_wr.hi.en) begin
            valid[hi_idx] <= 1'b1;
         end
         if (dsc_rd_en) begin
            dsc_rd_valid <= valid[dsc_rd_addr];
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/pcie_size_decode.sv
`timescale 1ns/100ps
`default_nettype none

module pcie_size_decode (
   input  logic                          pcie_clk,
   input  dma_pcie_pkg::pcie_size_code_t max_payload_size,
   input  dma_pcie_pkg::pcie_size_code_t max_read_req_size,
   output dma_pcie_pkg::pcie_bytes_t     payload_bytes,
   output dma_pcie_pkg::pcie_bytes_t     read_bytes
);

   import dma_pcie_pkg::*;

   function automatic pcie_bytes_t size_bytes(pcie_size_code_t code);
      case (code)
         SIZE_32:   return 10'd32;
         SIZE_64:   return 10'd64;
         SIZE_128:  return 10'd128;
         SIZE_256:  return 10'd256;
         SIZE_512:  return 10'd512;
         // 1024 does not fit in 10 bits
         SIZE_1024: return 10'd0;
         default:   return 10'd0;
      endcase
   endfunction

   // follows the link settings one cycle later
   always_ff @(posedge pcie_clk) begin
      payload_bytes <= size_bytes(max_payload_size);
      read_bytes    <= size_bytes(max_read_req_size);
   end

endmodule

`default_nettype wire

//--- hw/iface_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module iface_cfg_regs (
   input  logic                         pcie_clk,
   input  logic                         iface_rst_n,
   input  dma_iface_pkg::host_wr_t      cfg_wr,
   input  dma_iface_pkg::host_rd_t      cfg_rd,
   output dma_iface_pkg::host_rd_data_t cfg_rd_data,
   input  dma_pcie_pkg::pcie_bytes_t    payload_bytes,
   input  dma_pcie_pkg::pcie_bytes_t    read_bytes,
   output dma_iface_pkg::dsc_word_t     tx_dsc_mask,
   output dma_iface_pkg::dsc_word_t     rx_dsc_mask,
   output logic [15:0]                  rx_byte_wait,
   output logic                         soft_reset
);

   import dma_iface_pkg::*;

   host_word_t wait_merged;
   dsc_word_t  rd_word_hi;
   dsc_word_t  rd_word_lo;

   // byte enables, 1 takes the new byte
   function automatic host_word_t merge(host_word_t old_word, host_word_t new_word,
                                        byte_mask_t mask);
      host_word_t res;
      res = old_word;
      for (int b = 0; b < 4; b++) begin
         if (mask[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

   // full 64-bit view of one register index
   function automatic dsc_word_t cfg_word(mem_addr_t idx);
      case (idx)
         CFG_TX_DSC_MASK:  return tx_dsc_mask;
         CFG_RX_DSC_MASK:  return rx_dsc_mask;
         CFG_RX_BYTE_WAIT: return {48'd0, rx_byte_wait};
         CFG_PCIE_SIZES:   return {22'd0, read_bytes, 22'd0, payload_bytes};
         // control bit is a pulse, reads back 0
         default:          return 64'd0;
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // register writes
   // ----------------------------------------------------------------------
   assign wait_merged = merge({16'd0, rx_byte_wait}, cfg_wr.lo.data, cfg_wr.lo.mask);

   always_ff @(posedge pcie_clk) begin
      if (!iface_rst_n) begin
         tx_dsc_mask  <= '0;
         rx_dsc_mask  <= '0;
         rx_byte_wait <= '0;
         soft_reset   <= 1'b0;
      end else begin
         soft_reset <= 1'b0;
         if (cfg_wr.hi.en) begin
            case (cfg_wr.hi.addr)
               CFG_TX_DSC_MASK: tx_dsc_mask[63:32] <=
                  merge(tx_dsc_mask[63:32], cfg_wr.hi.data, cfg_wr.hi.mask);
               CFG_RX_DSC_MASK: rx_dsc_mask[63:32] <=
                  merge(rx_dsc_mask[63:32], cfg_wr.hi.data, cfg_wr.hi.mask);
               default: ;
            endcase
         end
         if (cfg_wr.lo.en) begin
            case (cfg_wr.lo.addr)
               CFG_TX_DSC_MASK: tx_dsc_mask[31:0] <=
                  merge(tx_dsc_mask[31:0], cfg_wr.lo.data, cfg_wr.lo.mask);
               CFG_RX_DSC_MASK: rx_dsc_mask[31:0] <=
                  merge(rx_dsc_mask[31:0], cfg_wr.lo.data, cfg_wr.lo.mask);
               CFG_RX_BYTE_WAIT: rx_byte_wait <= wait_merged[15:0];
               CFG_CONTROL: soft_reset <= cfg_wr.lo.data[0] && cfg_wr.lo.mask[0];
               default: ;
            endcase
         end
      end
   end

   // ----------------------------------------------------------------------
   // registered reads
   // ----------------------------------------------------------------------
   always_comb begin
      rd_word_hi = cfg_word(cfg_rd.addr_hi);
      rd_word_lo = cfg_word(cfg_rd.addr_lo);
   end

   always_ff @(posedge pcie_clk) begin
      if (cfg_rd.en_hi) begin
         cfg_rd_data.hi <= rd_word_hi[63:32];
      end
      if (cfg_rd.en_lo) begin
         cfg_rd_data.lo <= rd_word_lo[31:0];
      end
   end

endmodule

`default_nettype wire

//--- hw/iface_access_mux.sv
`timescale 1ns/100ps
`default_nettype none

module iface_access_mux #(
   parameter int IFACE_ID = 0
) (
   input  logic                         pcie_clk,
   input  logic                         iface_rst_n,
   input  logic                         iface_rdy,
   input  dma_iface_pkg::host_wr_t      host_wr,
   input  dma_iface_pkg::host_rd_t      host_rd,
   output dma_iface_pkg::host_wr_t      cfg_wr,
   output dma_iface_pkg::host_wr_t      dsc_wr,
   output dma_iface_pkg::host_rd_t      cfg_rd,
   input  dma_iface_pkg::host_rd_data_t cfg_rd_data,
   output dma_iface_pkg::host_rd_data_t host_rd_data
);

   import dma_iface_pkg::*;

   localparam if_sel_t MY_IF = if_sel_t'(IFACE_ID);

   logic wr_here;
   logic rd_here;
   logic wr_cfg_sel;
   logic wr_dsc_sel;
   logic rd_cfg_sel;
   logic rd_cfg_hi_q;
   logic rd_cfg_lo_q;

   // ----------------------------------------------------------------------
   // request decode
   // ----------------------------------------------------------------------
   assign wr_here    = iface_rdy && (host_wr.if_sel == MY_IF);
   assign rd_here    = iface_rdy && (host_rd.if_sel == MY_IF);
   assign wr_cfg_sel = wr_here && (host_wr.mem_sel == MEM_CFG);
   assign wr_dsc_sel = wr_here && (host_wr.mem_sel == MEM_TX_DSC);
   // descriptor memory has no host read path
   assign rd_cfg_sel = rd_here && (host_rd.mem_sel == MEM_CFG);

   // targets only look at the lane enables
   always_comb begin
      cfg_wr       = host_wr;
      cfg_wr.hi.en = host_wr.hi.en && wr_cfg_sel;
      cfg_wr.lo.en = host_wr.lo.en && wr_cfg_sel;

      dsc_wr       = host_wr;
      dsc_wr.hi.en = host_wr.hi.en && wr_dsc_sel;
      dsc_wr.lo.en = host_wr.lo.en && wr_dsc_sel;

      cfg_rd       = host_rd;
      cfg_rd.en_hi = host_rd.en_hi && rd_cfg_sel;
      cfg_rd.en_lo = host_rd.en_lo && rd_cfg_sel;
   end

   // ----------------------------------------------------------------------
   // read return, one cycle after the enable
   // ----------------------------------------------------------------------

   // selection only moves on a read so the returned data holds
   always_ff @(posedge pcie_clk) begin
      if (!iface_rst_n) begin
         rd_cfg_hi_q <= 1'b0;
         rd_cfg_lo_q <= 1'b0;
      end else begin
         if (host_rd.en_hi) begin
            rd_cfg_hi_q <= rd_cfg_sel;
         end
         if (host_rd.en_lo) begin
            rd_cfg_lo_q <= rd_cfg_sel;
         end
      end
   end

   assign host_rd_data.hi = rd_cfg_hi_q ? cfg_rd_data.hi : NO_DATA;
   assign host_rd_data.lo = rd_cfg_lo_q ? cfg_rd_data.lo : NO_DATA;

endmodule

`default_nettype wire

//--- hw/iface_rst_seq.sv
`timescale 1ns/100ps
`default_nettype none

module iface_rst_seq (
   input  logic pcie_clk,
   input  logic rst_n,
   input  logic soft_reset,
   output logic iface_rst_n,
   output logic iface_rdy
);

   typedef enum logic {
      RST_WAIT,
      RST_IDLE
   } rst_state_t;

   rst_state_t state;
   logic [3:0] cnt;

   // either reset source restarts the 16 cycle hold
   always_ff @(posedge pcie_clk) begin
      if (!rst_n || soft_reset) begin
         state <= RST_WAIT;
         cnt   <= 4'd0;
      end else begin
         case (state)
            RST_WAIT: begin
               cnt <= cnt + 4'd1;
               // last count, counter wraps back to 0
               if (cnt == 4'hf) begin
                  state <= RST_IDLE;
               end
            end
            RST_IDLE: begin
               state <= RST_IDLE;
            end
            default: begin
               state <= RST_WAIT;
            end
         endcase
      end
   end

   assign iface_rst_n = (state == RST_IDLE);
   assign iface_rdy   = iface_rst_n;

endmodule

`default_nettype wire

//--- hw/dma_pcie_pkg.sv
`default_nettype none

package dma_pcie_pkg;

   // ----------------------------------------------------------------------
   // pcie link size settings
   // ----------------------------------------------------------------------

   // encoded max payload / max read request size from the link
   typedef logic [2:0] pcie_size_code_t;

   // byte count, 1024 wraps to 0
   typedef logic [9:0] pcie_bytes_t;

   localparam pcie_size_code_t SIZE_32   = 3'd0;
   localparam pcie_size_code_t SIZE_64   = 3'd1;
   localparam pcie_size_code_t SIZE_128  = 3'd2;
   localparam pcie_size_code_t SIZE_256  = 3'd3;
   localparam pcie_size_code_t SIZE_512  = 3'd4;
   localparam pcie_size_code_t SIZE_1024 = 3'd5;

   // codes 6 and 7 are reserved and decode to 0

endpackage

`default_nettype wire

//--- hw/dma_iface_pkg.sv
`default_nettype none

package dma_iface_pkg;

   // ----------------------------------------------------------------------
   // host access widths
   // ----------------------------------------------------------------------
   localparam int MEM_ADDR_BITS = 10;

   // one address per 64-bit entry, split into hi and lo lanes
   typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
   typedef logic [31:0]              host_word_t;
   typedef logic [3:0]               byte_mask_t;
   typedef logic [1:0]               if_sel_t;
   typedef logic [3:0]               mem_sel_t;
   typedef logic [63:0]              dsc_word_t;

   // memory numbers, anything else is unmapped
   localparam mem_sel_t MEM_CFG    = 4'd0;
   localparam mem_sel_t MEM_TX_DSC = 4'd1;

   // config register index, taken from the lane address
   localparam mem_addr_t CFG_TX_DSC_MASK  = 10'd0;
   localparam mem_addr_t CFG_RX_DSC_MASK  = 10'd1;
   localparam mem_addr_t CFG_RX_BYTE_WAIT = 10'd2;
   localparam mem_addr_t CFG_CONTROL      = 10'd3;
   localparam mem_addr_t CFG_PCIE_SIZES   = 10'd4;

   // returned for reads that hit nothing
   localparam host_word_t NO_DATA = 32'hdeadbeef;

   // ----------------------------------------------------------------------
   // host access structs
   // ----------------------------------------------------------------------
   typedef struct packed {
      mem_addr_t  addr;
      host_word_t data;
      byte_mask_t mask;
      logic       en;
   } host_lane_t;

   typedef struct packed {
      if_sel_t    if_sel;
      mem_sel_t   mem_sel;
      host_lane_t hi;
      host_lane_t lo;
   } host_wr_t;

   typedef struct packed {
      if_sel_t   if_sel;
      mem_sel_t  mem_sel;
      mem_addr_t addr_hi;
      logic      en_hi;
      mem_addr_t addr_lo;
      logic      en_lo;
   } host_rd_t;

   typedef struct packed {
      host_word_t hi;
      host_word_t lo;
   } host_rd_data_t;

endpackage

`default_nettype wire
